// ==== dataCache.f ====
hw/dcachePkg.sv
hw/dcacheController.sv
hw/dcacheWay.sv
hw/lruTable.sv
hw/dataCache.sv
verif/busMemoryModel.sv
verif/dataCacheTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = dataCacheTb
FILELIST = dataCache.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== verif/dataCacheTb.sv ====
`timescale 1ns/1ps

module dataCacheTb;
  import dcachePkg::*;

  localparam int numSets = 16;
  // Six tests times their worst-case miss time with a wide margin
  localparam int timeoutCycles = 20000;

  logic                clk;
  logic                reset;
  logic [addrBits-1:0] Addr;
  logic [wordBits-1:0] WriteData;
  logic [3:0]          ByteMask;
  logic                MemWrite;
  logic                MemtoReg;
  logic                enable;
  logic                IStall;
  logic [wordBits-1:0] ReadData;
  logic                Stall;
  logic                HRequest;
  logic                HWrite;
  logic [addrBits-1:0] HAddr;
  logic [wordBits-1:0] HWData;
  logic [wordBits-1:0] HRData;
  logic                BusReady;

  int errorCount = 0;
  int checkCount = 0;
  int protocolErrors = 0;
  int readBeats = 0;
  int writeBeats = 0;

  // Expected memory for the words that were stored to
  logic [wordBits-1:0] shadow [int];

  dataCache #(.numSets(numSets)) dut_i (
    .clk, .reset, .Addr, .WriteData, .ByteMask, .MemWrite, .MemtoReg, .enable, .IStall,
    .ReadData, .Stall, .HRequest, .HWrite, .HAddr, .HWData, .HRData, .BusReady
  );

  busMemoryModel memI (
    .clk, .reset, .HRequest, .HWrite, .HAddr, .HWData, .HRData, .BusReady
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (timeoutCycles) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", timeoutCycles);
    $display("Test FAILED");
    $finish;
  end

  // Bus watch counts completed words
  always @(negedge clk) begin
    if (!reset) begin
      assert (HRequest || !HWrite) else begin
        protocolErrors++;
        $display("HWrite was high while HRequest was low at %0t ns", $time);
      end
      if (BusReady && HRequest) begin
        if (HWrite) begin
          writeBeats++;
        end else begin
          readBeats++;
        end
      end
    end
  end

  // Same pattern the memory model powers up with
  function automatic logic [wordBits-1:0] initialWord(int wordAddr);
    logic [addrBits-3:0] wa;
    wa = (addrBits-2)'(wordAddr);
    return {~wa, 2'b10, wa, 2'b01};
  endfunction

  function automatic logic [wordBits-1:0] expectedWord(int wordAddr);
    if (shadow.exists(wordAddr)) begin
      return shadow[wordAddr];
    end
    return initialWord(wordAddr);
  endfunction

  function automatic logic [addrBits-1:0] makeAddr(logic [7:0] tag, logic [3:0] index,
                                                   logic [1:0] word);
    return {tag, index, word, 2'b00};
  endfunction

  task automatic storeShadow(input logic [addrBits-1:0] addr, input logic [wordBits-1:0] data,
                             input logic [3:0] mask);
    int                  idx;
    logic [wordBits-1:0] word;
    idx = int'(addr[addrBits-1:2]);
    word = expectedWord(idx);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    shadow[idx] = word;
  endtask

  task automatic checkValue(input string testName, input logic [wordBits-1:0] expected,
                            input logic [wordBits-1:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("FAILED %s: expected %h, actual %h", testName, expected, actual);
    end
  endtask

  task automatic accessCache(input logic [addrBits-1:0] addr, input logic write,
                             input logic [wordBits-1:0] wdata, input logic [3:0] mask,
                             output logic stalled, output logic [wordBits-1:0] rdata);
    @(posedge clk);
    #2;
    Addr = addr;
    WriteData = wdata;
    ByteMask = mask;
    MemWrite = write;
    MemtoReg = !write;
    // Stall is combinational so look at it mid-cycle
    @(negedge clk);
    stalled = Stall;
    while (Stall) begin
      @(negedge clk);
    end
    rdata = ReadData;
    @(posedge clk);
    #2;
    MemWrite = 1'b0;
    MemtoReg = 1'b0;
    if (write) begin
      storeShadow(addr, wdata, mask);
    end
  endtask

  task automatic loadAndCheck(input string testName, input logic [addrBits-1:0] addr,
                              input logic expectStall);
    logic                stalled;
    logic [wordBits-1:0] rdata;
    accessCache(addr, 1'b0, '0, 4'b0000, stalled, rdata);
    checkValue({testName, " stall"}, 32'(expectStall), 32'(stalled));
    checkValue({testName, " data"}, expectedWord(int'(addr[addrBits-1:2])), rdata);
  endtask

  task automatic storeAndCheck(input string testName, input logic [addrBits-1:0] addr,
                               input logic [wordBits-1:0] wdata, input logic [3:0] mask,
                               input logic expectStall);
    logic                stalled;
    logic [wordBits-1:0] rdata;
    accessCache(addr, 1'b1, wdata, mask, stalled, rdata);
    checkValue({testName, " stall"}, 32'(expectStall), 32'(stalled));
  endtask

  initial begin
    int readStart;
    int writeStart;
    reset = 1'b1;
    Addr = '0;
    WriteData = '0;
    ByteMask = 4'b0000;
    MemWrite = 1'b0;
    MemtoReg = 1'b0;
    enable = 1'b1;
    IStall = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;

    // Reset state and then a cold load that must miss
    @(negedge clk);
    checkValue("reset Stall", 0, 32'(Stall));
    checkValue("reset HRequest", 0, 32'(HRequest));
    loadAndCheck("reset first load", makeAddr(8'h10, 4'd0, 2'd0), 1'b1);

    // Miss fills the block so the neighbour word hits
    loadAndCheck("read miss", makeAddr(8'h10, 4'd1, 2'd1), 1'b1);
    loadAndCheck("read hit", makeAddr(8'h10, 4'd1, 2'd3), 1'b0);

    // Partial store hit
    storeAndCheck("byte store", makeAddr(8'h10, 4'd1, 2'd3), 32'hA5C3_3C5A, 4'b0101, 1'b0);
    loadAndCheck("byte store readback", makeAddr(8'h10, 4'd1, 2'd3), 1'b0);

    // A, B, A, C in set 5 evicts B and keeps A
    loadAndCheck("lru load A", makeAddr(8'h21, 4'd5, 2'd0), 1'b1);
    loadAndCheck("lru load B", makeAddr(8'h22, 4'd5, 2'd0), 1'b1);
    loadAndCheck("lru reload A", makeAddr(8'h21, 4'd5, 2'd1), 1'b0);
    loadAndCheck("lru load C", makeAddr(8'h23, 4'd5, 2'd2), 1'b1);
    loadAndCheck("lru A kept", makeAddr(8'h21, 4'd5, 2'd2), 1'b0);
    loadAndCheck("lru B evicted", makeAddr(8'h22, 4'd5, 2'd3), 1'b1);

    // Two dirty blocks in set 9 pushed out by C and D
    storeAndCheck("dirty store A", makeAddr(8'h31, 4'd9, 2'd2), 32'hDEAD_BEEF, 4'b1111, 1'b1);
    storeAndCheck("dirty store B", makeAddr(8'h32, 4'd9, 2'd1), 32'h1234_5678, 4'b1111, 1'b1);
    writeStart = writeBeats;
    loadAndCheck("dirty load C", makeAddr(8'h33, 4'd9, 2'd0), 1'b1);
    loadAndCheck("dirty load D", makeAddr(8'h34, 4'd9, 2'd0), 1'b1);
    checkValue("dirty writeback words", 32'(2 * blockWords), 32'(writeBeats - writeStart));
    loadAndCheck("dirty reload A", makeAddr(8'h31, 4'd9, 2'd2), 1'b1);
    loadAndCheck("dirty reload B", makeAddr(8'h32, 4'd9, 2'd1), 1'b1);

    // Bypass loads take one bus word each
    @(posedge clk);
    #2;
    enable = 1'b0;
    readStart = readBeats;
    writeStart = writeBeats;
    loadAndCheck("bypass stored word", makeAddr(8'h31, 4'd9, 2'd2), 1'b1);
    checkValue("bypass read words", 1, 32'(readBeats - readStart));
    checkValue("bypass write words", 0, 32'(writeBeats - writeStart));
    readStart = readBeats;
    loadAndCheck("bypass fresh word", makeAddr(8'h40, 4'd12, 2'd3), 1'b1);
    checkValue("bypass second read words", 1, 32'(readBeats - readStart));
    enable = 1'b1;

    repeat (2) @(posedge clk);
    $display("Checks: %0d, value errors: %0d, bus protocol errors: %0d",
             checkCount, errorCount, protocolErrors);
    if (errorCount == 0 && protocolErrors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/busMemoryModel.sv ====
`timescale 1ns/1ps

module busMemoryModel (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           HRequest,
  input  logic                           HWrite,
  input  logic [dcachePkg::addrBits-1:0] HAddr,
  input  logic [dcachePkg::wordBits-1:0] HWData,
  output logic [dcachePkg::wordBits-1:0] HRData,
  output logic                           BusReady
);
  import dcachePkg::*;

  localparam int wordAddrBits = addrBits - byteOffsetBits;
  localparam int numWords = 1 << wordAddrBits;

  logic [wordBits-1:0]     mem [numWords];
  int                      seed;
  int                      waitLeft;
  logic                    armed;
  logic                    req;
  logic                    wr;
  logic                    strobe;
  logic [wordAddrBits-1:0] wordAddr;
  logic [wordBits-1:0]     wdata;

  // Power-up contents {~a, 2'b10, a, 2'b01} for word address a
  function automatic logic [wordBits-1:0] fillWord(int a);
    logic [wordAddrBits-1:0] w;
    w = wordAddrBits'(a);
    return {~w, 2'b10, w, 2'b01};
  endfunction

  assign HRData = mem[HAddr[addrBits-1:byteOffsetBits]];

  initial begin
    seed = 42394;
    armed = 1'b0;
    waitLeft = 0;
    BusReady = 1'b0;
    for (int a = 0; a < numWords; a++) begin
      mem[a] = fillWord(a);
    end
    forever begin
      // Bus state as it was just before the edge
      @(posedge clk);
      req = HRequest;
      wr = HWrite;
      strobe = BusReady;
      wordAddr = HAddr[addrBits-1:byteOffsetBits];
      wdata = HWData;
      #2;
      if (reset) begin
        armed = 1'b0;
        BusReady = 1'b0;
      end else if (strobe) begin
        // A write word lands at its strobe edge
        if (wr) begin
          mem[wordAddr] = wdata;
        end
        BusReady = 1'b0;
      end else if (!req) begin
        armed = 1'b0;
      end else if (!armed) begin
        armed = 1'b1;
        waitLeft = int'($unsigned($random(seed)) % 32'd3);
      end else if (waitLeft == 0) begin
        armed = 1'b0;
        BusReady = 1'b1;
      end else begin
        waitLeft--;
      end
    end
  end

endmodule

// ==== hw/dataCache.sv ====
`timescale 1ns/1ps

module dataCache #(
  parameter int numSets = 16,
  localparam int indexBits = $clog2(numSets),
  localparam int tagBits = dcachePkg::addrBits - dcachePkg::lineOffsetBits - indexBits
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [dcachePkg::addrBits-1:0] Addr,
  input  logic [dcachePkg::wordBits-1:0] WriteData,
  input  logic [3:0]                     ByteMask,
  input  logic                           MemWrite,
  input  logic                           MemtoReg,
  input  logic                           enable,
  input  logic                           IStall,
  output logic [dcachePkg::wordBits-1:0] ReadData,
  output logic                           Stall,
  output logic                           HRequest,
  output logic                           HWrite,
  output logic [dcachePkg::addrBits-1:0] HAddr,
  output logic [dcachePkg::wordBits-1:0] HWData,
  input  logic [dcachePkg::wordBits-1:0] HRData,
  input  logic                           BusReady
);
  import dcachePkg::*;

  logic [tagBits-1:0]   Tag;
  logic [tagBits-1:0]   W1Tag;
  logic [tagBits-1:0]   W2Tag;
  logic [tagBits-1:0]   CachedTag;
  logic [tagBits-1:0]   busTag;
  logic [indexBits-1:0] Index;
  logic [1:0]           WordOffset;
  logic [1:0]           Counter;
  logic [1:0]           CacheRDSel;
  logic [1:0]           NewWordOffset;
  logic [1:0]           wordSel;
  logic [3:0]           ActiveByteMask;
  logic [wordBits-1:0]  way1Data;
  logic [wordBits-1:0]  way2Data;
  logic [wordBits-1:0]  wayWData;
  logic [wordBits-1:0]  busWord;
  logic W1V, W2V, W1D, W2D, CurrLRU;
  logic RDSel, CWE, BlockWE, W1WE, W2WE, W1EN, UseWD, W1Hit, LruUpdate;
  logic setDirty;

  // Address fields
  assign Tag        = Addr[addrBits-1 -: tagBits];
  assign Index      = Addr[lineOffsetBits +: indexBits];
  assign WordOffset = Addr[byteOffsetBits +: wordOffsetBits];

  dcacheController #(.numSets(numSets)) ctrlI (
    .clk, .reset, .enable,
    .W1V, .W2V, .W1D, .W2D, .CurrLRU,
    .IStall, .MemWrite, .MemtoReg, .BusReady,
    .WordOffset, .ByteMask, .Tag, .W1Tag, .W2Tag,
    .RDSel, .CWE, .Stall, .HWrite, .HRequest, .BlockWE,
    .W1WE, .W2WE, .W1EN, .UseWD, .W1Hit, .LruUpdate,
    .Counter, .CacheRDSel, .ActiveByteMask, .NewWordOffset, .CachedTag
  );

  // Writes use the fill word, reads use the read word
  assign wordSel = CWE ? NewWordOffset : CacheRDSel;

  // Bus bytes during refill, except the bytes a passing store owns
  always_comb begin
    for (int b = 0; b < byteLanes; b++) begin
      if (BlockWE && !(UseWD && ByteMask[b])) begin
        wayWData[8*b +: 8] = HRData[8*b +: 8];
      end else begin
        wayWData[8*b +: 8] = WriteData[8*b +: 8];
      end
    end
  end

  assign setDirty = MemWrite & UseWD;

  dcacheWay #(.numSets(numSets)) way1I (
    .clk, .reset, .Index, .WordSel(wordSel),
    .WE(W1WE), .BlockFill(BlockWE), .SetDirty(setDirty),
    .TagIn(Tag), .WData(wayWData), .ByteEn(ActiveByteMask),
    .TagOut(W1Tag), .Valid(W1V), .Dirty(W1D), .RData(way1Data)
  );

  dcacheWay #(.numSets(numSets)) way2I (
    .clk, .reset, .Index, .WordSel(wordSel),
    .WE(W2WE), .BlockFill(BlockWE), .SetDirty(setDirty),
    .TagIn(Tag), .WData(wayWData), .ByteEn(ActiveByteMask),
    .TagOut(W2Tag), .Valid(W2V), .Dirty(W2D), .RData(way2Data)
  );

  lruTable #(.numSets(numSets)) lruI (
    .clk, .reset, .Index,
    .Update(LruUpdate), .UsedW1(W1EN), .CurrLRU
  );

  // Last word seen on the bus, for bypass loads
  always_ff @(posedge clk) begin
    if (BusReady) begin
      busWord <= HRData;
    end
  end

  assign ReadData = RDSel ? busWord : (W1Hit ? way1Data : way2Data);

  // Victim data on writeback, store data on a bypass write
  assign HWData = enable ? (W1EN ? way1Data : way2Data) : WriteData;

  // Writeback goes to the victim's block, everything else to the request
  assign busTag = (HWrite & enable) ? CachedTag : Tag;
  assign HAddr  = {busTag, Index, Counter, {byteOffsetBits{1'b0}}};

endmodule

// ==== hw/lruTable.sv ====
`timescale 1ns/1ps

module lruTable #(
  parameter int numSets = 16,
  localparam int indexBits = $clog2(numSets)
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [indexBits-1:0] Index,
  input  logic                 Update,
  input  logic                 UsedW1,
  output logic                 CurrLRU
);

  // High means way 1 goes next
  logic [numSets-1:0] lruBits;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (Update) begin
      // Replace the way that was not just used
      lruBits[Index] <= ~UsedW1;
    end
  end

  assign CurrLRU = lruBits[Index];

endmodule

// ==== hw/dcacheWay.sv ====
`timescale 1ns/1ps

module dcacheWay #(
  parameter int numSets = 16,
  localparam int indexBits = $clog2(numSets),
  localparam int tagBits = dcachePkg::addrBits - dcachePkg::lineOffsetBits - indexBits
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [indexBits-1:0]          Index,
  input  logic [1:0]                    WordSel,
  input  logic                          WE,
  input  logic                          BlockFill,
  input  logic                          SetDirty,
  input  logic [tagBits-1:0]            TagIn,
  input  logic [dcachePkg::wordBits-1:0] WData,
  input  logic [3:0]                    ByteEn,
  output logic [tagBits-1:0]            TagOut,
  output logic                          Valid,
  output logic                          Dirty,
  output logic [dcachePkg::wordBits-1:0] RData
);
  import dcachePkg::*;

  logic [wordBits-1:0] dataMem [numSets][blockWords];
  logic [tagBits-1:0]  tagMem [numSets];
  logic [numSets-1:0]  validBits;
  logic [numSets-1:0]  dirtyBits;
  logic                lastWord;
  logic                firstWord;

  assign lastWord  = (WordSel == 2'(blockWords - 1));
  assign firstWord = (WordSel == 2'd0);

  // Block data and tags
  always_ff @(posedge clk) begin
    if (WE) begin
      for (int b = 0; b < byteLanes; b++) begin
        if (ByteEn[b]) begin
          dataMem[Index][WordSel][8*b +: 8] <= WData[8*b +: 8];
        end
      end
      if (BlockFill && lastWord) begin
        tagMem[Index] <= TagIn;
      end
    end
  end

  // Line becomes valid once the whole block is in
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits <= '0;
    end else if (WE && BlockFill && lastWord) begin
      validBits[Index] <= 1'b1;
    end
  end

  // Refill starts clean, a merged store word makes it dirty again
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      dirtyBits <= '0;
    end else if (WE) begin
      if (SetDirty) begin
        dirtyBits[Index] <= 1'b1;
      end else if (BlockFill && firstWord) begin
        dirtyBits[Index] <= 1'b0;
      end
    end
  end

  assign TagOut = tagMem[Index];
  assign Valid  = validBits[Index];
  assign Dirty  = dirtyBits[Index];
  assign RData  = dataMem[Index][WordSel];

endmodule

// ==== hw/dcacheController.sv ====
`timescale 1ns/1ps

module dcacheController #(
  parameter int numSets = 16,
  localparam int tagBits = dcachePkg::addrBits - dcachePkg::lineOffsetBits - $clog2(numSets)
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               enable,
  input  logic               W1V,
  input  logic               W2V,
  input  logic               W1D,
  input  logic               W2D,
  input  logic               CurrLRU,
  input  logic               IStall,
  input  logic               MemWrite,
  input  logic               MemtoReg,
  input  logic               BusReady,
  input  logic [1:0]         WordOffset,
  input  logic [3:0]         ByteMask,
  input  logic [tagBits-1:0] Tag,
  input  logic [tagBits-1:0] W1Tag,
  input  logic [tagBits-1:0] W2Tag,
  output logic               RDSel,
  output logic               CWE,
  output logic               Stall,
  output logic               HWrite,
  output logic               HRequest,
  output logic               BlockWE,
  output logic               W1WE,
  output logic               W2WE,
  output logic               W1EN,
  output logic               UseWD,
  output logic               W1Hit,
  output logic               LruUpdate,
  output logic [1:0]         Counter,
  output logic [1:0]         CacheRDSel,
  output logic [3:0]         ActiveByteMask,
  output logic [1:0]         NewWordOffset,
  output logic [tagBits-1:0] CachedTag
);
  import dcachePkg::*;

  cacheState  state;
  cacheState  curState;
  cacheState  nextState;
  logic [1:0] wordCount;
  logic       access;
  logic       W2Hit;
  logic       hit;
  logic       dirty;
  logic       lastBeat;
  logic       ResetCounter;

  assign access = MemWrite | MemtoReg;

  // Tag compare against both ways
  assign W1Hit = W1V & (Tag == W1Tag);
  assign W2Hit = W2V & (Tag == W2Tag);
  assign hit   = W1Hit | W2Hit;

  // Way to touch is the hitting way, else an empty way, else the LRU choice
  always_comb begin
    if (W2Hit) begin
      W1EN = 1'b0;
    end else if (W1Hit || !W1V) begin
      W1EN = 1'b1;
    end else if (!W2V) begin
      W1EN = 1'b0;
    end else begin
      W1EN = CurrLRU;
    end
  end

  assign CachedTag = W1EN ? W1Tag : W2Tag;
  assign dirty     = W1EN ? (W1V & W1D) : (W2V & W2D);

  // A miss in Ready already acts as the first cycle of its transfer,
  // so Stall and HRequest rise in the request cycle
  always_comb begin
    curState = state;
    if (state == Ready && access) begin
      if (!enable) begin
        curState = Disabled;
      end else if (!hit) begin
        curState = dirty ? WriteBack : MemRead;
      end
    end
  end

  // Bus word counter runs only during block transfers
  assign ResetCounter = !(curState == WriteBack || curState == MemRead);
  assign lastBeat     = BusReady & (wordCount == 2'(blockWords - 1));

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      wordCount <= '0;
    end else if (ResetCounter) begin
      wordCount <= '0;
    end else if (BusReady) begin
      wordCount <= wordCount + 2'd1;
    end
  end

  // Bypass transfers go straight to the requested word
  assign Counter = enable ? wordCount : WordOffset;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= Ready;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    case (curState)
      WriteBack: nextState = lastBeat ? MemRead : WriteBack;
      MemRead:   nextState = lastBeat ? NextInstr : MemRead;
      Disabled:  nextState = BusReady ? NextInstr : Disabled;
      NextInstr: nextState = IStall ? Wait : Ready;
      Wait:      nextState = IStall ? Wait : Ready;
      default:   nextState = Ready;
    endcase
  end

  assign Stall    = (curState == WriteBack) | (curState == MemRead) |
                    (curState == Disabled);
  assign HRequest = Stall;
  assign HWrite   = (curState == WriteBack) | ((curState == Disabled) & MemWrite);
  assign BlockWE  = (curState == MemRead);

  // Store hit or one refill word per strobe
  assign CWE  = ((curState == Ready) & MemWrite) | (BlockWE & BusReady);
  assign W1WE = W1EN & CWE;
  assign W2WE = ~W1EN & CWE;

  // Hits and completed fills both count as a use of the set
  assign LruUpdate = ((curState == Ready) & access) | (BlockWE & lastBeat);

  // Store word merges into the refill as it passes by
  assign UseWD          = ~BlockWE | (MemWrite & (wordCount == WordOffset));
  assign ActiveByteMask = BlockWE ? 4'b1111 : ByteMask;

  // Way read word follows the counter while writing back
  assign CacheRDSel    = (curState == WriteBack) ? wordCount : WordOffset;
  assign NewWordOffset = ResetCounter ? WordOffset : wordCount;

  // Bypass loads return the captured bus word
  assign RDSel = ~enable & ((state == NextInstr) | (state == Wait));

endmodule

// ==== hw/dcachePkg.sv ====
package dcachePkg;

  // Data word width in bits
  localparam int wordBits = 32;

  // Byte lanes in one data word
  localparam int byteLanes = wordBits / 8;

  // Words per cache block, fixed by the two-bit transfer counter
  localparam int blockWords = 4;

  // Processor byte address width
  localparam int addrBits = 16;

  // Address bits that pick a byte inside a word
  localparam int byteOffsetBits = $clog2(byteLanes);

  // Address bits that pick a word inside a block
  localparam int wordOffsetBits = $clog2(blockWords);

  // Everything below the set index
  localparam int lineOffsetBits = wordOffsetBits + byteOffsetBits;

  // Controller states
  // Ready     idle, serves hits
  // WriteBack dirty victim goes out to memory
  // MemRead   block refill from memory
  // NextInstr miss done, pipeline released
  // Wait      holds while the instruction side stalls
  // Disabled  single-word bypass transfer
  typedef enum logic [2:0] {
    Ready,
    MemRead,
    WriteBack,
    NextInstr,
    Wait,
    Disabled
  } cacheState;

endpackage
